/* src.f */
+incdir+src
src/wisc_pkg.sv
src/wisc_regfile.sv
src/wisc_decode.sv
src/wisc_execute.sv
src/wisc_result.sv
src/wisc_top.sv
tb/wisc_clock_gen.sv
tb/wisc_tb.sv

/* Bender.yml */
package:
  name: wisc

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/wisc_pkg.sv
      - src/wisc_regfile.sv
      - src/wisc_decode.sv
      - src/wisc_execute.sv
      - src/wisc_result.sv
      - src/wisc_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/wisc_clock_gen.sv
      - tb/wisc_tb.sv

/* tb/wisc_tb.sv */
// Testbench with instruction and data memories, ISA reference model, programs and store checks
`timescale 1ns/1ps
`default_nettype none
`include "wisc_config.svh"

module wisc_tb;

	logic        clk, rst, rst_req;
	logic [15:0] imem_addr, imem_word, dmem_addr, dmem_wdata, dmem_rdata;
	logic        dmem_we, halted;
	logic [15:0] imem [512];
	logic [15:0] dmem [256];
	logic [15:0] prog_mem [512];   // Staged program image
	logic [15:0] init_mem [256];   // Data image loaded at reset
	logic [15:0] ref_mem [256];    // Model's final data image
	logic [15:0] ref_reg [16];
	logic [31:0] exp_q [$];        // Predicted stores as {addr, data}
	logic [15:0] prog [$];
	logic [15:0] lfsr;
	string       test_name;
	int          test_errors, n_pass, n_fail, store_slot;

	wisc_clock_gen clock_gen_inst (.clk(clk), .rst(rst), .rst_req(rst_req));

	wisc_top wisc_top_inst (
		.clk(clk), .rst(rst),
		.imem_addr(imem_addr), .imem_data(imem_word),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
		.dmem_rdata(dmem_rdata), .halted(halted)
	);

	assign imem_word = imem[imem_addr[8:0]];   // Combinational fetch

	// Synchronous read returns data while the load is in result
	always @(posedge clk) begin
		if (dmem_we) begin
			dmem[dmem_addr[7:0]] <= dmem_wdata;
		end
		dmem_rdata <= dmem[dmem_addr[7:0]];
	end

	// Store checker sampled mid-cycle
	always @(negedge clk) begin
		logic [31:0] expected;
		if (!rst && dmem_we) begin
			assert (!halted) else begin
				$display("Store after halt in test %s", test_name);
				test_errors++;
			end
			assert (exp_q.size() > 0) else begin
				$display("Unexpected store in test %s to address %h", test_name, dmem_addr);
				test_errors++;
			end
			if (exp_q.size() > 0) begin
				expected = exp_q.pop_front();
				assert ({dmem_addr, dmem_wdata} == expected) else begin
					$display("Mismatch in test %s: expected %h, actual %h", test_name,
						expected, {dmem_addr, dmem_wdata});
					test_errors++;
				end
			end
		end
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic void emit(input logic [15:0] w);
		prog.push_back(w);
	endfunction

	function automatic void load_const(input logic [3:0] rd, input logic [15:0] v);
		emit({`WISC_OP_LLB, rd, v[7:0]});
		emit({`WISC_OP_LHB, rd, v[15:8]});
	endfunction

	// Store through r14 and bump the base by r13 every eight slots
	function automatic void emit_store(input logic [3:0] rt);
		emit({`WISC_OP_SW, rt, 4'd14, 4'(store_slot)});
		store_slot++;
		if (store_slot == 8) begin
			emit({`WISC_OP_ADD, 4'd14, 4'd14, 4'd13});
			store_slot = 0;
		end
	endfunction

	function automatic void begin_prog();
		prog.delete();
		store_slot = 0;
		foreach (init_mem[i]) init_mem[i] = {8'(i) ^ 8'h5A, ~8'(i)};   // Address-keyed fill
		emit({`WISC_OP_LLB, 4'd14, 8'h40});   // Store base
		emit({`WISC_OP_LLB, 4'd13, 8'h08});   // Base stride
		emit({`WISC_OP_LLB, 4'd12, 8'h01});   // Unit step
	endfunction

	// Instruction-level model of the ISA
	task automatic run_model();
		logic [15:0] pc, npc, w, a, b, res, addr;
		logic [16:0] s;
		logic [3:0]  dst;
		logic        z, v, n, wr, taken;
		int          steps;
		pc = '0;
		z = 1'b0;
		v = 1'b0;
		n = 1'b0;
		foreach (ref_reg[i]) ref_reg[i] = '0;
		foreach (ref_mem[i]) ref_mem[i] = init_mem[i];
		exp_q.delete();
		for (steps = 0; steps < 4000; steps++) begin
			w = prog_mem[pc[8:0]];
			a = ref_reg[w[7:4]];
			b = ref_reg[w[3:0]];
			npc = pc + 16'd1;
			dst = w[11:8];
			wr = 1'b1;
			res = '0;
			case (w[15:12])
				`WISC_OP_ADD, `WISC_OP_SUB: begin
					s = (w[15:12] == `WISC_OP_ADD) ? ({a[15], a} + {b[15], b}) :
						({a[15], a} - {b[15], b});
					v = (s[16] != s[15]);   // Result left the signed range
					res = v ? (s[16] ? 16'h8000 : 16'h7FFF) : s[15:0];
					z = (res == '0);
					n = res[15];
				end
				`WISC_OP_AND: res = a & b;
				`WISC_OP_NOR: res = ~(a | b);
				`WISC_OP_SLL: res = a << w[3:0];
				`WISC_OP_SRL: res = a >> w[3:0];
				`WISC_OP_SRA: res = $signed(a) >>> w[3:0];
				`WISC_OP_LW, `WISC_OP_SW: begin
					addr = a + {{12{w[3]}}, w[3:0]};
					if (w[15:12] == `WISC_OP_LW) begin
						res = ref_mem[addr[7:0]];
					end else begin
						wr = 1'b0;
						ref_mem[addr[7:0]] = ref_reg[dst];
						exp_q.push_back({addr, ref_reg[dst]});
					end
				end
				`WISC_OP_LHB: res = {w[7:0], ref_reg[dst][7:0]};
				`WISC_OP_LLB: res = {ref_reg[dst][15:8], w[7:0]};
				`WISC_OP_B: begin
					wr = 1'b0;
					case (w[11:9])
						`WISC_CC_NEQ:  taken = !z;
						`WISC_CC_EQ:   taken = z;
						`WISC_CC_GT:   taken = !z && !n;
						`WISC_CC_LT:   taken = n;
						`WISC_CC_GTE:  taken = z || (!z && !n);
						`WISC_CC_LTE:  taken = n || z;
						`WISC_CC_OVFL: taken = v;
						default:       taken = 1'b1;
					endcase
					if (taken) npc = npc + {{7{w[8]}}, w[8:0]};
				end
				`WISC_OP_CALL: begin
					dst = 4'd15;
					res = npc;   // Return address
					npc = npc + {{7{w[8]}}, w[8:0]};
				end
				`WISC_OP_RET: begin
					wr = 1'b0;
					npc = ref_reg[15];
				end
				`WISC_OP_HLT: return;
				default: wr = 1'b0;
			endcase
			if ((w[15:12] >= `WISC_OP_AND) && (w[15:12] <= `WISC_OP_SRA)) begin
				z = (res == '0);   // Logic and shift ops move Z only
			end
			if (wr && dst != 4'd0) ref_reg[dst] = res;
			pc = npc;
		end
		$display("Reference model ran out of steps in test %s", test_name);
		test_errors++;
	endtask

	task automatic run_test(input string name);
		int cycles;
		test_name = name;
		test_errors = 0;
		foreach (prog_mem[i]) prog_mem[i] = (i < prog.size()) ? prog[i] : 16'hF000;
		run_model();
		@(posedge clk);
		foreach (imem[i]) imem[i] <= prog_mem[i];
		foreach (dmem[i]) dmem[i] <= init_mem[i];
		rst_req <= 1'b1;
		@(posedge clk);
		rst_req <= 1'b0;
		@(negedge clk);
		cycles = 0;
		while (rst && cycles < 50) begin   // Reset release
			@(negedge clk);
			cycles++;
		end
		cycles = 0;
		while (!rst && !halted && cycles < 5000) begin
			@(negedge clk);
			cycles++;
		end
		if (rst || !halted) begin
			$display("Timeout in test %s: the core never halted", name);
			$display("Test FAILED");
			$finish;
		end else begin
			repeat (8) @(negedge clk);   // Window for stray stores
			foreach (dmem[i]) begin
				assert (dmem[i] === ref_mem[i]) else begin
					$display("Mismatch in test %s at dmem[%0d]: expected %h, actual %h",
						name, i, ref_mem[i], dmem[i]);
					test_errors++;
				end
			end
			assert (exp_q.size() == 0) else begin
				$display("Test %s ended with %0d predicted stores missing", name, exp_q.size());
				test_errors++;
			end
			if (test_errors == 0) n_pass++;
			else n_fail++;
			$display("%-8s %s (%0d errors)", name, (test_errors == 0) ? "pass" : "fail",
				test_errors);
		end
	endtask

	task automatic build_alu();
		logic [15:0] x, y;
		begin_prog();
		x = rand_bits(16);
		y = rand_bits(16);
		load_const(4'd1, x);
		load_const(4'd2, y);
		emit({`WISC_OP_ADD, 4'd5, 4'd1, 4'd2});
		emit_store(4'd5);
		emit({`WISC_OP_SUB, 4'd6, 4'd1, 4'd2});
		emit_store(4'd6);
		emit({`WISC_OP_AND, 4'd7, 4'd1, 4'd2});
		emit_store(4'd7);
		emit({`WISC_OP_NOR, 4'd8, 4'd1, 4'd2});
		emit_store(4'd8);
		emit({`WISC_OP_SLL, 4'd9, 4'd1, 4'(rand_bits(4))});
		emit_store(4'd9);
		emit({`WISC_OP_SRL, 4'd10, 4'd1, 4'(rand_bits(4))});
		emit_store(4'd10);
		emit({`WISC_OP_SRA, 4'd11, 4'd1, 4'(rand_bits(4))});
		emit_store(4'd11);
		load_const(4'd3, 16'h7000);   // Saturation operands
		load_const(4'd4, 16'h9000);
		emit({`WISC_OP_ADD, 4'd5, 4'd3, 4'd3});
		emit_store(4'd5);
		emit({`WISC_OP_ADD, 4'd6, 4'd4, 4'd4});
		emit_store(4'd6);
		emit({`WISC_OP_SUB, 4'd7, 4'd3, 4'd4});
		emit_store(4'd7);
		emit({`WISC_OP_SUB, 4'd8, 4'd4, 4'd3});
		emit_store(4'd8);
		emit(16'hF000);
	endtask

	task automatic build_chain();
		logic [3:0] p, q, op;
		begin_prog();
		load_const(4'd1, rand_bits(16));
		load_const(4'd5, rand_bits(16));
		p = 4'd1;
		for (int k = 0; k < 12; k++) begin
			q = {2'b00, p[1:0]} + 4'd1;   // Each op consumes the last result
			op = {1'b0, 3'(rand_bits(3))};
			if (op == 4'd7) op = `WISC_OP_ADD;
			if (op >= `WISC_OP_SLL) emit({op, q, p, 4'(rand_bits(4))});
			else emit({op, q, p, 4'd5});
			p = q;
		end
		for (int r = 1; r <= 5; r++) emit_store(4'(r));
		emit(16'hF000);
	endtask

	task automatic build_load();
		logic [3:0] off;
		begin_prog();
		for (int i = 0; i < 8; i++) init_mem[8'h80 + i] = rand_bits(16);
		emit({`WISC_OP_LLB, 4'd1, 8'h84});
		for (int k = 0; k < 6; k++) begin
			off = 4'(rand_bits(3)) + 4'hC;   // -4 to +3 around the base
			emit({`WISC_OP_LW, 4'd2, 4'd1, off});
			emit({`WISC_OP_ADD, 4'd3, 4'd2, 4'd2});   // Use right after the load
			emit_store(4'd3);
			emit_store(4'd2);
		end
		emit(16'hF000);
	endtask

	task automatic build_branch();
		logic [3:0] op, rt;
		begin_prog();
		for (int c = 0; c < 16; c++) begin
			load_const(4'd1, rand_bits(16));
			load_const(4'd2, rand_bits(16));
			rt = rand_bits(1) ? 4'd1 : 4'd2;          // Same operand forces zero on SUB
			op = rand_bits(1) ? `WISC_OP_ADD : `WISC_OP_SUB;
			emit({op, 4'd3, 4'd1, rt});
			emit({`WISC_OP_B, 3'(c), 9'd3});
			emit({`WISC_OP_LLB, 4'd4, 8'hA0 + 8'(c)});    // Fall-through marker
			emit({`WISC_OP_SW, 4'd4, 4'd14, 4'd0});
			emit({`WISC_OP_B, `WISC_CC_UNCOND, 9'd2});
			emit({`WISC_OP_LLB, 4'd4, 8'hB0 + 8'(c)});    // Taken marker
			emit({`WISC_OP_SW, 4'd4, 4'd14, 4'd0});
			emit({`WISC_OP_ADD, 4'd14, 4'd14, 4'd12});
		end
		emit(16'hF000);
	endtask

	task automatic build_call();
		int call_a, call_b, sub;
		begin_prog();
		load_const(4'd1, rand_bits(16));
		call_a = prog.size();
		emit(16'h0);   // Patched below
		emit({`WISC_OP_LLB, 4'd2, 8'h5A});
		emit({`WISC_OP_SW, 4'd2, 4'd14, 4'd1});
		load_const(4'd1, rand_bits(16));
		call_b = prog.size();
		emit(16'h0);
		emit({`WISC_OP_LLB, 4'd2, 8'hA5});
		emit({`WISC_OP_SW, 4'd2, 4'd14, 4'd1});
		emit(16'hF000);
		sub = prog.size();
		emit({`WISC_OP_SW, 4'd1, 4'd14, 4'd0});
		emit({`WISC_OP_ADD, 4'd14, 4'd14, 4'd12});
		emit({`WISC_OP_RET, 12'h000});
		prog[call_a] = {`WISC_OP_CALL, 3'b000, 9'(sub - call_a - 1)};
		prog[call_b] = {`WISC_OP_CALL, 3'b000, 9'(sub - call_b - 1)};
	endtask

	task automatic build_halt();
		begin_prog();
		load_const(4'd1, rand_bits(16));
		emit_store(4'd1);
		emit(16'hF000);
		emit({`WISC_OP_SW, 4'd1, 4'd14, 4'd5});   // Past HLT and never executed
		emit({`WISC_OP_SW, 4'd1, 4'd14, 4'd6});
	endtask

	initial begin
		rst_req = 1'b0;
		dmem_rdata = '0;
		lfsr = 16'd19898;
		n_pass = 0;
		n_fail = 0;
		test_errors = 0;
		test_name = "idle";
		foreach (imem[i]) imem[i] = 16'hF000;
		foreach (dmem[i]) dmem[i] = '0;
		build_alu();
		run_test("alu");
		build_chain();
		run_test("chain");
		build_load();
		run_test("load");
		build_branch();
		run_test("branch");
		build_call();
		run_test("call");
		build_halt();
		run_test("halt");
		$display("Tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
		if (n_fail == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb/wisc_clock_gen.sv */
// Testbench clock source and reset pulse generator
`timescale 1ns/1ps
`default_nettype none

module wisc_clock_gen (
	output logic      clk,
	output logic      rst,
	input  wire logic rst_req   // One-cycle request for a new reset pulse
);

	int cnt;

	initial begin
		clk = 1'b0;
		rst = 1'b1;   // Power-on reset
		cnt = 0;
	end

	always #5 clk = ~clk;   // 10 ns period

	always @(posedge clk) begin
		if (rst_req) begin
			rst <= 1'b1;
			cnt <= 0;
		end else if (rst) begin
			cnt <= cnt + 1;
			if (cnt == 9) begin
				rst <= 1'b0;   // Ten cycles high
			end
		end
	end

endmodule

`default_nettype wire

/* src/wisc_top.sv */
// Core top level joining decode, register file, execute and result to the memory ports
`timescale 1ns/1ps
`default_nettype none
`include "wisc_config.svh"

module wisc_top (
	input  wire logic                    clk,
	input  wire logic                    rst,
	output logic      [`WISC_DATA_W-1:0] imem_addr,
	input  wire wisc_pkg::instr_u        imem_data,
	output logic      [`WISC_DATA_W-1:0] dmem_addr,
	output logic      [`WISC_DATA_W-1:0] dmem_wdata,
	output logic                         dmem_we,
	input  wire logic [`WISC_DATA_W-1:0] dmem_rdata,
	output logic                         halted
);

	import wisc_pkg::*;

	logic                    redirect;          // Execute to decode
	logic [`WISC_DATA_W-1:0] redirect_pc;
	logic                    ex_valid, ex_we;   // Hazard view of execute
	logic [3:0]              ex_rd;
	logic [3:0]              rf_raddr_a, rf_raddr_b;
	logic [`WISC_DATA_W-1:0] rf_rdata_a, rf_rdata_b;
	logic                    rf_we;             // Result to register file
	logic [3:0]              rf_waddr;
	logic [`WISC_DATA_W-1:0] rf_wdata;
	logic                    id_valid;
	alu_op_e                 id_alu_op;
	logic [`WISC_DATA_W-1:0] id_opa, id_opb, id_imm, id_pc;
	logic [3:0]              id_rd;
	logic                    id_we, id_load, id_store, id_branch, id_call, id_ret, id_halt;
	logic [2:0]              id_cond;
	logic [`WISC_DATA_W-1:0] ex_result;
	logic                    ex_load, ex_halt;

	wisc_decode decode_inst (
		.clk(clk), .rst(rst),
		.imem_addr(imem_addr), .imem_data(imem_data),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.ex_valid(ex_valid), .ex_we(ex_we), .ex_rd(ex_rd),
		.rf_raddr_a(rf_raddr_a), .rf_raddr_b(rf_raddr_b),
		.rf_rdata_a(rf_rdata_a), .rf_rdata_b(rf_rdata_b),
		.id_valid(id_valid), .id_alu_op(id_alu_op),
		.id_opa(id_opa), .id_opb(id_opb), .id_imm(id_imm),
		.id_rd(id_rd), .id_we(id_we), .id_load(id_load), .id_store(id_store),
		.id_branch(id_branch), .id_call(id_call), .id_ret(id_ret),
		.id_halt(id_halt), .id_cond(id_cond), .id_pc(id_pc)
	);

	wisc_regfile regfile_inst (
		.clk(clk), .rst(rst),
		.raddr_a(rf_raddr_a), .raddr_b(rf_raddr_b),
		.rdata_a(rf_rdata_a), .rdata_b(rf_rdata_b),
		.we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
	);

	wisc_execute execute_inst (
		.clk(clk), .rst(rst),
		.id_valid(id_valid), .id_alu_op(id_alu_op),
		.id_opa(id_opa), .id_opb(id_opb), .id_imm(id_imm),
		.id_rd(id_rd), .id_we(id_we), .id_load(id_load), .id_store(id_store),
		.id_branch(id_branch), .id_call(id_call), .id_ret(id_ret),
		.id_halt(id_halt), .id_cond(id_cond), .id_pc(id_pc),
		.ex_valid(ex_valid), .ex_we(ex_we), .ex_rd(ex_rd),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
		.ex_result(ex_result), .ex_load(ex_load), .ex_halt(ex_halt)
	);

	wisc_result result_inst (
		.clk(clk), .rst(rst),
		.ex_valid(ex_valid), .ex_we(ex_we), .ex_rd(ex_rd),
		.ex_result(ex_result), .ex_load(ex_load), .ex_halt(ex_halt),
		.dmem_rdata(dmem_rdata),
		.rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.halted(halted)
	);

endmodule

`default_nettype wire

/* src/wisc_result.sv */
// Memory/writeback register, load or ALU data selection, register write, halt flag
`timescale 1ns/1ps
`default_nettype none
`include "wisc_config.svh"

module wisc_result (
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire logic                    ex_valid,
	input  wire logic                    ex_we,
	input  wire logic [3:0]              ex_rd,
	input  wire logic [`WISC_DATA_W-1:0] ex_result,
	input  wire logic                    ex_load,
	input  wire logic                    ex_halt,
	input  wire logic [`WISC_DATA_W-1:0] dmem_rdata,  // Arrives while the load sits here
	output logic                         rf_we,
	output logic      [3:0]              rf_waddr,
	output logic      [`WISC_DATA_W-1:0] rf_wdata,
	output logic                         halted
);

	logic                    wb_valid;
	logic                    wb_we;
	logic [3:0]              wb_rd;
	logic [`WISC_DATA_W-1:0] wb_result;
	logic                    wb_load;
	logic                    wb_halt;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
			halted   <= 1'b0;
		end else begin
			wb_valid <= ex_valid;
			if (wb_valid && wb_halt) begin
				halted <= 1'b1;     // Sticky until reset
			end
		end
	end

	always_ff @(posedge clk) begin
		wb_we     <= ex_we;
		wb_rd     <= ex_rd;
		wb_result <= ex_result;
		wb_load   <= ex_load;
		wb_halt   <= ex_halt;
	end

	assign rf_we    = wb_valid && wb_we;
	assign rf_waddr = wb_rd;
	assign rf_wdata = wb_load ? dmem_rdata : wb_result;

endmodule

`default_nettype wire

/* src/wisc_execute.sv */
// Decode/execute register, saturating ALU, flags, branch resolution, data-memory request
`timescale 1ns/1ps
`default_nettype none
`include "wisc_config.svh"

module wisc_execute (
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire logic                    id_valid,
	input  wire wisc_pkg::alu_op_e       id_alu_op,
	input  wire logic [`WISC_DATA_W-1:0] id_opa,
	input  wire logic [`WISC_DATA_W-1:0] id_opb,
	input  wire logic [`WISC_DATA_W-1:0] id_imm,
	input  wire logic [3:0]              id_rd,
	input  wire logic                    id_we,
	input  wire logic                    id_load,
	input  wire logic                    id_store,
	input  wire logic                    id_branch,
	input  wire logic                    id_call,
	input  wire logic                    id_ret,
	input  wire logic                    id_halt,
	input  wire logic [2:0]              id_cond,
	input  wire logic [`WISC_DATA_W-1:0] id_pc,
	output logic                         ex_valid,
	output logic                         ex_we,
	output logic      [3:0]              ex_rd,
	output logic                         redirect,
	output logic      [`WISC_DATA_W-1:0] redirect_pc,
	output logic      [`WISC_DATA_W-1:0] dmem_addr,
	output logic      [`WISC_DATA_W-1:0] dmem_wdata,
	output logic                         dmem_we,
	output logic      [`WISC_DATA_W-1:0] ex_result,
	output logic                         ex_load,
	output logic                         ex_halt
);

	import wisc_pkg::*;

	alu_op_e                 alu_op;
	logic [`WISC_DATA_W-1:0] opa, opb, imm, pc;
	logic                    load, store, branch, call, ret, halt;
	logic [2:0]              cond;
	logic                    flag_z, flag_v, flag_n;
	logic [`WISC_DATA_W-1:0] sum, dif, sat_val, alu_out, pc_next;
	logic                    add_ovf, sub_ovf, alu_ovf, set_flags, taken;

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= id_valid;       // Already squashed on stall or redirect
		end
	end

	always_ff @(posedge clk) begin
		alu_op <= id_alu_op;
		opa    <= id_opa;
		opb    <= id_opb;
		imm    <= id_imm;
		pc     <= id_pc;
		ex_rd  <= id_rd;
		ex_we  <= id_we;
		load   <= id_load;
		store  <= id_store;
		branch <= id_branch;
		call   <= id_call;
		ret    <= id_ret;
		halt   <= id_halt;
		cond   <= id_cond;
	end

	assign sum     = opa + opb;
	assign dif     = opa - opb;
	assign add_ovf = (opa[15] == opb[15]) && (sum[15] != opa[15]);
	assign sub_ovf = (opa[15] != opb[15]) && (dif[15] != opa[15]);
	assign sat_val = {opa[15], {(`WISC_DATA_W-1){~opa[15]}}};  // Clamp toward opa's sign

	always_comb begin
		alu_ovf = 1'b0;
		case (alu_op)
			alu_add: begin
				alu_ovf = add_ovf;
				alu_out = add_ovf ? sat_val : sum;
			end
			alu_sub: begin
				alu_ovf = sub_ovf;
				alu_out = sub_ovf ? sat_val : dif;
			end
			alu_and: alu_out = opa & opb;
			alu_nor: alu_out = ~(opa | opb);
			alu_sll: alu_out = opa << imm[3:0];
			alu_srl: alu_out = opa >> imm[3:0];
			alu_sra: alu_out = $signed(opa) >>> imm[3:0];
			default: alu_out = {opb[7:0], opa[7:0]};        // LHB and LLB
		endcase
	end

	// Only register-result ALU ops touch flags, byte loads leave them alone
	assign set_flags = ex_valid && ex_we && !load && !call && (alu_op != alu_lhb);

	always_ff @(posedge clk) begin
		if (rst) begin
			flag_z <= 1'b0;
			flag_v <= 1'b0;
			flag_n <= 1'b0;
		end else if (set_flags) begin
			flag_z <= (alu_out == '0);
			if ((alu_op == alu_add) || (alu_op == alu_sub)) begin
				flag_v <= alu_ovf;
				flag_n <= alu_out[15];
			end
		end
	end

	always_comb begin
		taken = 1'b0;
		case (cond)
			`WISC_CC_NEQ:    taken = !flag_z;
			`WISC_CC_EQ:     taken = flag_z;
			`WISC_CC_GT:     taken = !flag_z && !flag_n;
			`WISC_CC_LT:     taken = flag_n;
			`WISC_CC_GTE:    taken = flag_z || !flag_n;
			`WISC_CC_LTE:    taken = flag_z || flag_n;
			`WISC_CC_OVFL:   taken = flag_v;
			`WISC_CC_UNCOND: taken = 1'b1;
			default: ;
		endcase
	end

	assign pc_next     = pc + 1'b1;
	assign redirect    = ex_valid && ((branch && taken) || call || ret);
	assign redirect_pc = ret ? opa : pc_next + imm;   // RET jumps to r15

	assign dmem_addr  = opa + imm;                    // Wrapping, no saturation
	assign dmem_wdata = opb;
	assign dmem_we    = ex_valid && store;

	assign ex_result = call ? pc_next : alu_out;      // Return address into r15
	assign ex_load   = ex_valid && load;
	assign ex_halt   = ex_valid && halt;

endmodule

`default_nettype wire

/* src/wisc_decode.sv */
// PC and fetch, fetch/decode register, instruction decode, RAW stall and flush
`timescale 1ns/1ps
`default_nettype none
`include "wisc_config.svh"

module wisc_decode (
	input  wire logic                    clk,
	input  wire logic                    rst,
	output logic      [`WISC_DATA_W-1:0] imem_addr,
	input  wire wisc_pkg::instr_u        imem_data,
	input  wire logic                    redirect,      // Taken branch, CALL or RET
	input  wire logic [`WISC_DATA_W-1:0] redirect_pc,
	input  wire logic                    ex_valid,
	input  wire logic                    ex_we,
	input  wire logic [3:0]              ex_rd,
	output logic      [3:0]              rf_raddr_a,
	output logic      [3:0]              rf_raddr_b,
	input  wire logic [`WISC_DATA_W-1:0] rf_rdata_a,
	input  wire logic [`WISC_DATA_W-1:0] rf_rdata_b,
	output logic                         id_valid,
	output wisc_pkg::alu_op_e            id_alu_op,
	output logic      [`WISC_DATA_W-1:0] id_opa,
	output logic      [`WISC_DATA_W-1:0] id_opb,
	output logic      [`WISC_DATA_W-1:0] id_imm,
	output logic      [3:0]              id_rd,
	output logic                         id_we,
	output logic                         id_load,
	output logic                         id_store,
	output logic                         id_branch,
	output logic                         id_call,
	output logic                         id_ret,
	output logic                         id_halt,
	output logic      [2:0]              id_cond,
	output logic      [`WISC_DATA_W-1:0] id_pc
);

	import wisc_pkg::*;

	logic [`WISC_DATA_W-1:0] pc;
	instr_u                  fd_instr;      // Fetch/decode register
	logic [`WISC_DATA_W-1:0] fd_pc;
	logic                    fd_valid;
	logic                    halt_seen;     // Fetch frozen after HLT
	logic [3:0]              opcode;
	logic                    stall;
	logic                    stop_fetch;

	assign imem_addr  = pc;
	assign opcode     = fd_instr.rrr_v.opcode;  // Same field in every view
	assign id_pc      = fd_pc;
	assign id_cond    = fd_instr.ctl_v.cond;
	assign stop_fetch = halt_seen || (fd_valid && (opcode == `WISC_OP_HLT));

	// One bubble while the producer sits in execute, write-through covers the rest
	assign stall = fd_valid && ex_valid && ex_we && (ex_rd != 4'd0) &&
		((rf_raddr_a == ex_rd) || (rf_raddr_b == ex_rd));
	assign id_valid = fd_valid && !stall && !redirect;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc        <= `WISC_RESET_PC;
			fd_valid  <= 1'b0;
			halt_seen <= 1'b0;
		end else if (redirect) begin
			pc       <= redirect_pc;    // Flush the wrong-path word
			fd_valid <= 1'b0;
		end else if (!stall) begin
			if (stop_fetch) begin
				fd_valid  <= 1'b0;
				halt_seen <= 1'b1;
			end else begin
				pc       <= pc + 1'b1;
				fd_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			fd_instr <= imem_data;
			fd_pc    <= pc;
		end
	end

	// Field view chosen by opcode, unused read ports park on r0
	always_comb begin
		rf_raddr_a = 4'd0;
		rf_raddr_b = 4'd0;
		id_alu_op  = alu_add;
		id_imm     = '0;
		id_rd      = 4'd0;
		id_we      = 1'b0;
		id_load    = 1'b0;
		id_store   = 1'b0;
		id_branch  = 1'b0;
		id_call    = 1'b0;
		id_ret     = 1'b0;
		id_halt    = 1'b0;
		case (opcode)
			`WISC_OP_ADD, `WISC_OP_SUB, `WISC_OP_AND, `WISC_OP_NOR: begin
				rf_raddr_a = fd_instr.rrr_v.rs;
				rf_raddr_b = fd_instr.rrr_v.rt;
				id_rd      = fd_instr.rrr_v.rd;
				id_alu_op  = alu_op_e'(opcode[2:0]);
				id_we      = 1'b1;
			end
			`WISC_OP_SLL, `WISC_OP_SRL, `WISC_OP_SRA: begin
				rf_raddr_a = fd_instr.shift_v.rs;
				id_rd      = fd_instr.shift_v.rd;
				id_imm     = {{(`WISC_DATA_W-4){1'b0}}, fd_instr.shift_v.shamt};
				id_alu_op  = alu_op_e'(opcode[2:0]);
				id_we      = 1'b1;
			end
			`WISC_OP_LW, `WISC_OP_SW: begin
				rf_raddr_a = fd_instr.mem_v.rs;                 // Base
				id_imm     = {{(`WISC_DATA_W-4){fd_instr.mem_v.offset[3]}},
					fd_instr.mem_v.offset};
				id_load    = (opcode == `WISC_OP_LW);
				id_store   = (opcode == `WISC_OP_SW);
				id_we      = id_load;
				id_rd      = fd_instr.mem_v.rt;
				if (id_store) begin
					rf_raddr_b = fd_instr.mem_v.rt;             // Store data
				end
			end
			`WISC_OP_LHB, `WISC_OP_LLB: begin
				rf_raddr_a = fd_instr.byte_v.rd;                // Keeps the other byte
				id_rd      = fd_instr.byte_v.rd;
				id_imm     = {{(`WISC_DATA_W-8){1'b0}}, fd_instr.byte_v.imm};
				id_alu_op  = alu_lhb;
				id_we      = 1'b1;
			end
			`WISC_OP_B, `WISC_OP_CALL: begin
				id_imm    = {{(`WISC_DATA_W-9){fd_instr.ctl_v.offset[8]}},
					fd_instr.ctl_v.offset};
				id_branch = (opcode == `WISC_OP_B);
				id_call   = (opcode == `WISC_OP_CALL);
				id_we     = id_call;
				id_rd     = 4'd15;                              // Link register
			end
			`WISC_OP_RET: begin
				rf_raddr_a = 4'd15;
				id_ret     = 1'b1;
			end
			`WISC_OP_HLT: id_halt = 1'b1;
			default: ;
		endcase
	end

	// Byte insertion takes {opb[7:0], opa[7:0]}
	always_comb begin
		id_opa = rf_rdata_a;
		id_opb = rf_rdata_b;
		if (opcode == `WISC_OP_LHB) begin
			id_opb = id_imm;                                    // New high byte
		end else if (opcode == `WISC_OP_LLB) begin
			id_opa = id_imm;                                    // New low byte
			id_opb = {8'h00, rf_rdata_a[15:8]};                 // Old high byte
		end
	end

endmodule

`default_nettype wire

/* src/wisc_regfile.sv */
// Sixteen-entry register file, two read ports, one write port with write-through
`timescale 1ns/1ps
`default_nettype none
`include "wisc_config.svh"

module wisc_regfile (
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire logic [3:0]              raddr_a,
	input  wire logic [3:0]              raddr_b,
	output logic      [`WISC_DATA_W-1:0] rdata_a,
	output logic      [`WISC_DATA_W-1:0] rdata_b,
	input  wire logic                    we,
	input  wire logic [3:0]              waddr,
	input  wire logic [`WISC_DATA_W-1:0] wdata
);

	logic [`WISC_DATA_W-1:0] regs [`WISC_REG_CNT];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `WISC_REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != 4'd0)) begin   // r0 never written
			regs[waddr] <= wdata;
		end
	end

	// Write data bypasses the array so decode sees a result in its write cycle
	assign rdata_a = (raddr_a == 4'd0) ? '0 :
		(we && (waddr == raddr_a)) ? wdata : regs[raddr_a];
	assign rdata_b = (raddr_b == 4'd0) ? '0 :
		(we && (waddr == raddr_b)) ? wdata : regs[raddr_b];

endmodule

`default_nettype wire

/* src/wisc_pkg.sv */
// Instruction word views and ALU operation encoding
`default_nettype none

package wisc_pkg;

	// Low three opcode bits of ADD..SRA map straight onto this
	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_nor = 3'd3,
		alu_sll = 3'd4,
		alu_srl = 3'd5,
		alu_sra = 3'd6,
		alu_lhb = 3'd7    // Byte insertion, LHB and LLB
	} alu_op_e;

	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;
	} rrr_t;

	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] shamt;
	} shift_t;

	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] rt;         // Load target or store source
		logic [3:0] rs;         // Base
		logic [3:0] offset;     // Signed word offset
	} mem_t;

	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] rd;
		logic [7:0] imm;
	} byte_t;

	typedef struct packed {
		logic [3:0] opcode;
		logic [2:0] cond;
		logic [8:0] offset;     // Signed, relative to PC+1
	} ctl_t;

	typedef union packed {
		rrr_t   rrr_v;
		shift_t shift_v;
		mem_t   mem_v;
		byte_t  byte_v;
		ctl_t   ctl_v;
	} instr_u;

endpackage

`default_nettype wire

/* src/wisc_config.svh */
// Data width, register count, opcode and branch condition encodings, reset PC
`ifndef WISC_CONFIG_SVH
`define WISC_CONFIG_SVH

`define WISC_DATA_W   16        // Data and address width
`define WISC_REG_CNT  16        // Architectural registers
`define WISC_RESET_PC 16'h0000  // First fetch after reset

// Opcodes in instruction bits 15 to 12
`define WISC_OP_ADD  4'b0000
`define WISC_OP_SUB  4'b0001
`define WISC_OP_AND  4'b0010
`define WISC_OP_NOR  4'b0011
`define WISC_OP_SLL  4'b0100
`define WISC_OP_SRL  4'b0101
`define WISC_OP_SRA  4'b0110
`define WISC_OP_LW   4'b1000
`define WISC_OP_SW   4'b1001
`define WISC_OP_LHB  4'b1010
`define WISC_OP_LLB  4'b1011
`define WISC_OP_B    4'b1100
`define WISC_OP_CALL 4'b1101
`define WISC_OP_RET  4'b1110
`define WISC_OP_HLT  4'b1111

// Branch conditions in bits 11 to 9
`define WISC_CC_NEQ    3'b000
`define WISC_CC_EQ     3'b001
`define WISC_CC_GT     3'b010
`define WISC_CC_LT     3'b011
`define WISC_CC_GTE    3'b100
`define WISC_CC_LTE    3'b101
`define WISC_CC_OVFL   3'b110
`define WISC_CC_UNCOND 3'b111

`endif
